/* Makefile */
SRCS := $(shell grep -v '^+' files.f)

.PHONY: run clean

obj_dir/Vtb_mem_subsys: files.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_mem_subsys \
		-f files.f -o Vtb_mem_subsys

run: obj_dir/Vtb_mem_subsys
	./obj_dir/Vtb_mem_subsys | tee sim.log
	@if grep -q "Test failed" sim.log; then exit 1; fi
	@if ! grep -q "Test completed successfully" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log

/* files.f */
hdl/mem_pkg.sv
hdl/mem_align_check.sv
hdl/mem_store_format.sv
hdl/mem_access.sv
hdl/data_sram.sv
hdl/mem_subsys.sv
verification/tb_clock_gen.sv
verification/tb_mem_subsys.sv

/* hdl/data_sram.sv */
`timescale 1ns/10ps

module data_sram #(
    parameter int SRAM_DEPTH = 256
) (
    input                              clk,
    input  mem_pkg::sram_req_t         sram,
    output logic [mem_pkg::DATA_W-1:0] rdata
);

    localparam int IDX_W = $clog2(SRAM_DEPTH);

    logic [mem_pkg::DATA_W-1:0] mem [SRAM_DEPTH];
    logic [IDX_W-1:0]           idx;

    assign idx = sram.addr[IDX_W+1:2]; // word address

    always_ff @(posedge clk) begin
        if (sram.en) begin
            for (int i = 0; i < 4; i++) begin
                if (sram.wen[i]) begin
                    mem[idx][i*8 +: 8] <= sram.wdata[i*8 +: 8];
                end
            end
            rdata <= mem[idx]; // old word on a same-cycle write
        end
    end

    // the access stage only lets aligned word reads through
    a_word_read_aligned: assert property (@(posedge clk)
        (sram.en && sram.rlen == 2'd2) |-> (sram.addr[1:0] == 2'b00))
        else $error("word read at unaligned address %h", sram.addr);

    // halfword reads stay within one half of the word
    a_half_read_aligned: assert property (@(posedge clk)
        (sram.en && sram.rlen == 2'd1) |-> !sram.addr[0])
        else $error("halfword read at odd address %h", sram.addr);

endmodule

/* hdl/mem_access.sv */
`timescale 1ns/10ps

module mem_access #(
    parameter logic [31:0] IO_ADDR = 32'hbfaffff0
) (
    input                                 clk,
    input                                 rst_n,
    input  mem_pkg::mem_req_t             req,
    input  mem_pkg::except_t              except_in,
    output mem_pkg::except_t              except_out,
    output mem_pkg::sram_req_t            sram,
    input  logic [mem_pkg::DATA_W-1:0]    sram_rdata,
    output logic [mem_pkg::DATA_W-1:0]    rdata,
    output logic                          rdata_valid
);

    mem_pkg::lane_t  lane;
    logic            blocked;
    logic            io_hit;
    logic            load_go;

    // context of the load in flight
    logic            ld_valid;
    mem_pkg::mem_op_e ld_op;
    logic [1:0]      ld_off;
    logic            ld_io;

    logic [7:0]      sel_byte;
    logic [15:0]     sel_half;

    mem_align_check align_inst (
        .req        (req),
        .except_in  (except_in),
        .except_out (except_out)
    );

    mem_store_format format_inst (
        .req  (req),
        .lane (lane)
    );

    assign blocked = |except_out; // any exception bit kills the access
    assign io_hit  = req.addr == IO_ADDR;
    assign load_go = req.en && !blocked && mem_pkg::is_load(req.op);

    always_comb begin
        sram.en    = req.en && !blocked && !io_hit;
        sram.wen   = lane.wen;
        sram.rlen  = lane.rlen;
        sram.addr  = req.addr;
        sram.wdata = lane.wdata;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ld_valid <= 1'b0;
        end else begin
            ld_valid <= load_go;
        end
    end

    always_ff @(posedge clk) begin
        if (load_go) begin
            ld_op  <= req.op;
            ld_off <= req.addr[1:0];
            ld_io  <= io_hit;
        end
    end

    assign sel_byte = sram_rdata[ld_off*8 +: 8];
    assign sel_half = ld_off[1] ? sram_rdata[31:16] : sram_rdata[15:0];

    always_comb begin
        rdata = '0;
        if (ld_valid && !ld_io) begin
            case (ld_op)
                mem_pkg::OP_LW:  rdata = sram_rdata;
                mem_pkg::OP_LB:  rdata = {{24{sel_byte[7]}}, sel_byte};
                mem_pkg::OP_LBU: rdata = {24'd0, sel_byte};
                mem_pkg::OP_LH:  rdata = {{16{sel_half[15]}}, sel_half};
                mem_pkg::OP_LHU: rdata = {16'd0, sel_half};
                default:         rdata = '0;
            endcase
        end
    end

    assign rdata_valid = ld_valid; // io loads also pulse, with zero data

    // every result pulse traces back to an enabled load one cycle earlier
    a_valid_after_load: assert property (@(posedge clk) disable iff (!rst_n)
        rdata_valid |-> $past(req.en && mem_pkg::is_load(req.op)))
        else $error("rdata_valid without a load in the previous cycle");

endmodule

/* hdl/mem_align_check.sv */
`timescale 1ns/10ps

module mem_align_check (
    input  mem_pkg::mem_req_t req,
    input  mem_pkg::except_t  except_in,
    output mem_pkg::except_t  except_out
);

    logic half_op;
    logic word_op;
    logic misaligned;

    always_comb begin
        half_op = req.op inside {mem_pkg::OP_LH, mem_pkg::OP_LHU, mem_pkg::OP_SH};
        word_op = req.op inside {mem_pkg::OP_LW, mem_pkg::OP_SW};
        // byte accesses can sit anywhere
        misaligned = (half_op && req.addr[0]) ||
                     (word_op && (req.addr[1:0] != 2'b00));
    end

    always_comb begin
        except_out      = except_in; // upstream field unchanged
        except_out.adel = misaligned && mem_pkg::is_load(req.op);
        except_out.ades = misaligned && mem_pkg::is_store(req.op);
    end

    // an op is either a load or a store, never both
    always_comb begin
        assert final (!(except_out.adel && except_out.ades))
            else $error("adel and ades raised together for op %0h", req.op);
    end

endmodule

/* hdl/mem_pkg.sv */
package mem_pkg;

    localparam int DATA_W = 32;

    // opcodes follow the MIPS primary opcode field
    typedef enum logic [5:0] {
        OP_NONE = 6'b000000,
        OP_LB   = 6'b100000,
        OP_LH   = 6'b100001,
        OP_LW   = 6'b100011,
        OP_LBU  = 6'b100100,
        OP_LHU  = 6'b100101,
        OP_SB   = 6'b101000,
        OP_SH   = 6'b101001,
        OP_SW   = 6'b101011
    } mem_op_e;

    typedef struct packed {
        logic              en;
        mem_op_e           op;
        logic [31:0]       addr;
        logic [DATA_W-1:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic [6:0] upstream; // from earlier stages, passed through
        logic       adel;
        logic       ades;
    } except_t;

    typedef struct packed {
        logic [3:0]        wen;
        logic [DATA_W-1:0] wdata;
        logic [1:0]        rlen; // 0: 1 byte, 1: 2 bytes, 2: 4 bytes
    } lane_t;

    typedef struct packed {
        logic              en;
        logic [3:0]        wen;
        logic [1:0]        rlen;
        logic [31:0]       addr;
        logic [DATA_W-1:0] wdata;
    } sram_req_t;

    function automatic logic is_load(mem_op_e op);
        return op inside {OP_LW, OP_LB, OP_LBU, OP_LH, OP_LHU};
    endfunction

    function automatic logic is_store(mem_op_e op);
        return op inside {OP_SW, OP_SH, OP_SB};
    endfunction

endpackage

/* hdl/mem_store_format.sv */
`timescale 1ns/10ps

module mem_store_format (
    input  mem_pkg::mem_req_t req,
    output mem_pkg::lane_t    lane
);

    logic [1:0] offset;
    logic       word_aligned;
    logic       half_aligned;

    assign offset       = req.addr[1:0];
    assign word_aligned = offset == 2'b00;
    assign half_aligned = !offset[0];

    always_comb begin
        lane = '0; // loads never write
        case (req.op)
            mem_pkg::OP_LW: begin
                lane.rlen = 2'd2;
            end
            mem_pkg::OP_LH, mem_pkg::OP_LHU: begin
                lane.rlen = 2'd1;
            end
            mem_pkg::OP_LB, mem_pkg::OP_LBU: begin
                lane.rlen = 2'd0;
            end
            mem_pkg::OP_SW: begin
                if (word_aligned) begin
                    lane.wen   = 4'b1111;
                    lane.wdata = req.wdata;
                end
            end
            mem_pkg::OP_SH: begin
                if (half_aligned) begin
                    lane.wen   = offset[1] ? 4'b1100 : 4'b0011;
                    lane.wdata = {2{req.wdata[15:0]}}; // same half in both positions
                end
            end
            mem_pkg::OP_SB: begin
                lane.wen   = 4'b0001 << offset;
                lane.wdata = {4{req.wdata[7:0]}};
            end
            default: begin
                lane = '0;
            end
        endcase
    end

    // a load or idle op must never reach the SRAM as a write
    always_comb begin
        assert final ((lane.wen == 4'b0000) || mem_pkg::is_store(req.op))
            else $error("write enables %b for non-store op %0h", lane.wen, req.op);
    end

endmodule

/* hdl/mem_subsys.sv */
`timescale 1ns/10ps

module mem_subsys #(
    parameter int          SRAM_DEPTH = 256,
    parameter logic [31:0] IO_ADDR    = 32'hbfaffff0
) (
    input                              clk,
    input                              rst_n,
    input  mem_pkg::mem_req_t          req,
    input  mem_pkg::except_t           except_in,
    output mem_pkg::except_t           except_out,
    output logic [mem_pkg::DATA_W-1:0] rdata,
    output logic                       rdata_valid
);

    mem_pkg::sram_req_t         sram;
    logic [mem_pkg::DATA_W-1:0] sram_rdata;

    mem_access #(
        .IO_ADDR (IO_ADDR)
    ) access_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .req         (req),
        .except_in   (except_in),
        .except_out  (except_out),
        .sram        (sram),
        .sram_rdata  (sram_rdata),
        .rdata       (rdata),
        .rdata_valid (rdata_valid)
    );

    data_sram #(
        .SRAM_DEPTH (SRAM_DEPTH)
    ) sram_inst (
        .clk   (clk),
        .sram  (sram),
        .rdata (sram_rdata)
    );

endmodule

/* verification/tb_clock_gen.sv */
`timescale 1ns/10ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1; // released on a rising edge
    end

endmodule

/* verification/tb_mem_subsys.sv */
`timescale 1ns/10ps

module tb_mem_subsys;

    localparam int          SRAM_DEPTH   = 256;
    localparam logic [31:0] IO_ADDR      = 32'hbfaffff0;
    localparam int          RAND_OPS     = 400;
    localparam int          DIRECTED_REQ = 200; // directed tests plus idle gaps stay below this
    localparam int          TOTAL_REQ    = SRAM_DEPTH + DIRECTED_REQ + RAND_OPS;

    typedef struct {
        int          due; // cycle in which rdata_valid must be high
        logic [31:0] value;
    } pending_t;

    logic                 clk;
    logic                 rst_n;
    mem_pkg::mem_req_t    req;
    mem_pkg::except_t     except_in;
    mem_pkg::except_t     except_out;
    logic [31:0]          rdata;
    logic                 rdata_valid;

    logic [7:0]           model [SRAM_DEPTH*4]; // byte image of the SRAM
    pending_t             pending [$];
    int                   cyc;
    int                   checks;
    int                   errors;

    tb_clock_gen #(.PERIOD_NS(20), .RESET_CYCLES(8)) clock_inst (.clk(clk), .rst_n(rst_n));

    mem_subsys #(
        .SRAM_DEPTH (SRAM_DEPTH),
        .IO_ADDR    (IO_ADDR)
    ) mem_subsys_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .req         (req),
        .except_in   (except_in),
        .except_out  (except_out),
        .rdata       (rdata),
        .rdata_valid (rdata_valid)
    );

    function automatic int access_bytes(mem_pkg::mem_op_e op);
        case (op)
            mem_pkg::OP_LW, mem_pkg::OP_SW: return 4;
            mem_pkg::OP_LH, mem_pkg::OP_LHU, mem_pkg::OP_SH: return 2;
            default: return 1;
        endcase
    endfunction

    function automatic logic load_op(mem_pkg::mem_op_e op);
        return op inside {mem_pkg::OP_LW, mem_pkg::OP_LH, mem_pkg::OP_LHU,
                          mem_pkg::OP_LB, mem_pkg::OP_LBU};
    endfunction

    function automatic logic store_op(mem_pkg::mem_op_e op);
        return op inside {mem_pkg::OP_SW, mem_pkg::OP_SH, mem_pkg::OP_SB};
    endfunction

    function automatic int byte_idx(logic [31:0] addr);
        return int'(addr & (SRAM_DEPTH * 4 - 1)); // upper bits alias
    endfunction

    function automatic logic [31:0] fill_word(logic [31:0] addr);
        return (addr * 32'h9e3779b1) ^ {addr[15:0], addr[31:16]};
    endfunction

    // expected exception bus for one request
    function automatic mem_pkg::except_t exp_except(mem_pkg::mem_op_e op, logic [31:0] addr,
                                                    logic [6:0] up);
        mem_pkg::except_t e;
        logic             bad;
        bad = (addr & (access_bytes(op) - 1)) != 0;
        e = '0;
        e.upstream = up;
        e.adel = bad && load_op(op);
        e.ades = bad && store_op(op);
        return e;
    endfunction

    // expected load result from the byte model, little endian lanes
    function automatic logic [31:0] exp_load(mem_pkg::mem_op_e op, logic [31:0] addr);
        logic [31:0] v;
        int          b;
        v = '0;
        b = byte_idx(addr);
        if (addr == IO_ADDR) return 32'd0;
        for (int i = 0; i < access_bytes(op); i++) v[8*i +: 8] = model[b + i];
        if (op == mem_pkg::OP_LB) v = {{24{v[7]}}, v[7:0]};
        if (op == mem_pkg::OP_LH) v = {{16{v[15]}}, v[15:0]};
        return v;
    endfunction

    task automatic issue(input mem_pkg::mem_op_e op, input logic [31:0] addr,
                         input logic [31:0] wdata, input logic [6:0] up);
        mem_pkg::mem_req_t r;
        mem_pkg::except_t  e_in;
        mem_pkg::except_t  e_exp;
        pending_t          p;
        r.en = 1'b1;
        r.op = op;
        r.addr = addr;
        r.wdata = wdata;
        e_in = '0;
        e_in.upstream = up;
        @(posedge clk);
        req <= r;
        except_in <= e_in;
        @(negedge clk);
        e_exp = exp_except(op, addr, up);
        checks++;
        assert (except_out === e_exp) else begin
            $display("error at %0t: except_out expected %h, got %h", $time, e_exp, except_out);
            errors++;
        end
        if (e_exp == '0 && load_op(op)) begin
            p.due = cyc + 1;
            p.value = exp_load(op, addr);
            pending.push_back(p);
        end
        if (e_exp == '0 && store_op(op) && addr != IO_ADDR) begin
            for (int i = 0; i < access_bytes(op); i++) begin
                model[byte_idx(addr) + i] = wdata[8*i +: 8];
            end
        end
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            req <= '0;
            except_in <= '0;
        end
    endtask

    task automatic print_result(input string name, input int err0);
        idle(3); // let the last load result drain
        $display("%-20s done, %0d errors", name, errors - err0);
    endtask

    task automatic word_round_trip();
        logic [31:0] addrs [4];
        int          err0;
        addrs = '{32'h010, 32'h3fc, 32'h200, 32'h0a4};
        err0 = errors;
        foreach (addrs[i]) begin
            issue(mem_pkg::OP_SW, addrs[i], $urandom, 7'd0);
            issue(mem_pkg::OP_LW, addrs[i], 32'd0, 7'd0);
        end
        print_result("word round trip", err0);
    endtask

    task automatic subword_lanes();
        logic [7:0] bytes [4];
        int         err0;
        bytes = '{8'h85, 8'h7a, 8'hf0, 8'h11}; // both signs per lane pair
        err0 = errors;
        for (int off = 0; off < 4; off++) begin
            issue(mem_pkg::OP_SB, 32'h080 + off,
                  {16'($urandom_range(65535, 0)), 8'h00, bytes[off]}, 7'd0);
        end
        for (int off = 0; off < 4; off++) begin
            issue(mem_pkg::OP_LB, 32'h080 + off, 32'd0, 7'd0);
            issue(mem_pkg::OP_LBU, 32'h080 + off, 32'd0, 7'd0);
        end
        issue(mem_pkg::OP_SH, 32'h084, 32'h5a5a8001, 7'd0);
        issue(mem_pkg::OP_SH, 32'h086, 32'ha5a57ffe, 7'd0);
        for (int off = 0; off < 4; off += 2) begin
            issue(mem_pkg::OP_LH, 32'h084 + off, 32'd0, 7'd0);
            issue(mem_pkg::OP_LHU, 32'h084 + off, 32'd0, 7'd0);
        end
        print_result("sub-word lanes", err0);
    endtask

    task automatic misaligned_access();
        int err0;
        err0 = errors;
        issue(mem_pkg::OP_SW, 32'h141, 32'hdeadbeef, 7'd0);
        issue(mem_pkg::OP_SW, 32'h142, 32'hcafef00d, 7'd0);
        issue(mem_pkg::OP_SH, 32'h143, 32'h0000abcd, 7'd0);
        issue(mem_pkg::OP_LW, 32'h142, 32'd0, 7'd0); // must give no result
        issue(mem_pkg::OP_LH, 32'h141, 32'd0, 7'd0);
        issue(mem_pkg::OP_LW, 32'h140, 32'd0, 7'd0); // still the fill word
        print_result("misalignment", err0);
    endtask

    task automatic upstream_block();
        int err0;
        err0 = errors;
        issue(mem_pkg::OP_SW, 32'h180, 32'h12345678, 7'h04);
        issue(mem_pkg::OP_SB, 32'h181, 32'h000000ff, 7'h41);
        issue(mem_pkg::OP_LW, 32'h180, 32'd0, 7'h04);
        issue(mem_pkg::OP_LW, 32'h180, 32'd0, 7'd0);
        print_result("upstream exception", err0);
    endtask

    task automatic io_address();
        int err0;
        err0 = errors;
        issue(mem_pkg::OP_SW, IO_ADDR, 32'h87654321, 7'd0);
        issue(mem_pkg::OP_LW, IO_ADDR, 32'd0, 7'd0);
        issue(mem_pkg::OP_LB, IO_ADDR, 32'd0, 7'd0);
        issue(mem_pkg::OP_LW, IO_ADDR & 32'h3ff, 32'd0, 7'd0); // aliased word is untouched
        print_result("io address", err0);
    endtask

    task automatic random_mix();
        mem_pkg::mem_op_e ops [8];
        mem_pkg::mem_op_e op;
        logic [31:0]      addr;
        logic [6:0]       up;
        int               err0;
        ops = '{mem_pkg::OP_LW, mem_pkg::OP_LB, mem_pkg::OP_LBU, mem_pkg::OP_LH,
                mem_pkg::OP_LHU, mem_pkg::OP_SW, mem_pkg::OP_SH, mem_pkg::OP_SB};
        err0 = errors;
        for (int k = 0; k < RAND_OPS; k++) begin
            op = ops[$urandom_range(7, 0)];
            addr = $urandom & 32'h3ff;
            if ($urandom_range(3, 0) != 0) addr = addr & ~(access_bytes(op) - 1);
            if ($urandom_range(31, 0) == 0) addr = IO_ADDR;
            up = ($urandom_range(15, 0) == 0) ? 7'($urandom_range(127, 1)) : 7'd0;
            issue(op, addr, $urandom, up);
        end
        print_result("random mix", err0);
    endtask

    always @(posedge clk) cyc <= cyc + 1;

    // result checker, sampled mid-cycle when rdata is settled
    always @(negedge clk) begin : compare
        pending_t p;
        if (rst_n) begin
            if (rdata_valid) begin
                checks++;
                assert (pending.size() > 0 && pending[0].due == cyc) else begin
                    $display("rdata_valid pulsed at %0t with no load expecting it", $time);
                    errors++;
                end
                if (pending.size() > 0 && pending[0].due == cyc) begin
                    p = pending.pop_front();
                    assert (rdata === p.value) else begin
                        $display("error at %0t: rdata expected %h, got %h", $time, p.value, rdata);
                        errors++;
                    end
                end
            end else if (pending.size() > 0 && pending[0].due <= cyc) begin
                p = pending.pop_front();
                checks++;
                assert (0) else begin
                    $display("load result due at %0t never arrived", $time);
                    errors++;
                end
            end
        end
    end

    initial begin
        #((TOTAL_REQ + 8 + 100) * 20);
        $display("watchdog expired before the tests finished");
        $display("Test failed");
        $finish;
    end

    initial begin
        req = '0;
        except_in = '0;
        cyc = 0;
        checks = 0;
        errors = 0;
        void'($urandom(70));
        wait (rst_n === 1'b1);
        @(negedge clk);
        checks++;
        assert (rdata_valid === 1'b0 && rdata === 32'd0) else begin
            $display("outputs not idle after reset at %0t", $time);
            errors++;
        end
        for (int w = 0; w < SRAM_DEPTH; w++) begin
            issue(mem_pkg::OP_SW, 32'(w * 4), fill_word(32'(w * 4)), 7'd0);
        end
        idle(2);
        word_round_trip();
        subword_lanes();
        misaligned_access();
        upstream_block();
        io_address();
        random_mix();
        checks++;
        assert (pending.size() == 0) else begin
            $display("%0d load results still outstanding at the end", pending.size());
            errors++;
        end
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
